// File: reorder_buffer.f
hdl/rob_pkg.sv
hdl/rob_ptr_ctrl.sv
hdl/rob_entry_store.sv
hdl/rob_retire_stage.sv
hdl/reorder_buffer.sv
verification/reorder_buffer_asserts.sv
verification/reorder_buffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the reorder buffer testbench with Verilator and runs it.
# Exits with a failing status unless the run reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module reorder_buffer_tb -f reorder_buffer.f

sim_out=$(./obj_dir/Vreorder_buffer_tb 2>&1) || true
echo "$sim_out"

if grep -qx "TEST OK" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

// File: verification/reorder_buffer_tb.sv
// Testbench for the reorder buffer.
// Applies a per-cycle stimulus table, keeps a queue model of renamed entries
// and compares each cycle's rename tag, stall, retire and redirect with it.

module reorder_buffer_tb
    import rob_pkg::*;
();

    localparam int CDB_PORTS = 2;
    localparam int NUM_ROWS  = 38;
    localparam int TIMEOUT   = 2 * NUM_ROWS + 50;

    typedef struct packed {
        logic                     rename;
        logic                     enq_en;
        rob_enq_t                 enq;
        cdb_t [CDB_PORTS-1:0]     cdb;
        logic [ROB_TAG_WIDTH-1:0] exp_tag;
    } stim_row_t;

    typedef struct packed {
        logic [ROB_TAG_WIDTH-1:0] tag;
        rob_op_e                  op;
        logic [ADDR_WIDTH-1:0]    pc;
        logic [REG_IDX_WIDTH-1:0] rdest;
        logic                     rdy;
        logic                     redirect;
        logic [DATA_WIDTH-1:0]    data;
        logic [ADDR_WIDTH-1:0]    addr;
    } model_entry_t;

    typedef struct packed {
        logic [31:0]           cycle;
        rob_retire_t           rec;
        logic                  redirect;
        logic [ADDR_WIDTH-1:0] addr;
    } retire_event_t;

    logic                     clk;
    logic                     n_rst;
    logic                     i_rename_en;
    logic                     i_enq_en;
    rob_enq_t                 i_enq;
    cdb_t                     i_cdb [CDB_PORTS];
    logic [ROB_TAG_WIDTH-1:0] o_rename_tag;
    logic                     o_rob_stall;
    logic                     o_retire_en;
    rob_retire_t              o_retire;
    logic                     o_redirect;
    logic [ADDR_WIDTH-1:0]    o_redirect_addr;

    stim_row_t                stim [NUM_ROWS];
    model_entry_t             model_q [$];
    retire_event_t            expect_q [$];
    logic                     model_redirect;
    logic [ROB_TAG_WIDTH-1:0] model_tail;
    logic [ROB_TAG_WIDTH-1:0] last_tag;
    int                       err_cnt;
    int                       chk_cnt;
    int                       retire_seen;
    int                       redirect_seen;
    int                       cycle_cnt = 0;

    reorder_buffer #(
        .CDB_PORTS (CDB_PORTS)
    ) reorder_buffer_inst (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_rename_en     (i_rename_en),
        .o_rename_tag    (o_rename_tag),
        .o_rob_stall     (o_rob_stall),
        .i_enq_en        (i_enq_en),
        .i_enq           (i_enq),
        .i_cdb           (i_cdb),
        .o_retire_en     (o_retire_en),
        .o_retire        (o_retire),
        .o_redirect      (o_redirect),
        .o_redirect_addr (o_redirect_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Simulation did not finish within %0d cycles", TIMEOUT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic tag_range(input int first, input int last, input int tag);
        for (int r = first; r <= last; r++) begin
            stim[r].exp_tag = ROB_TAG_WIDTH'(tag);
        end
    endtask

    task automatic enqueue_at(input int r, input rob_op_e op, input logic [31:0] pc,
                              input logic [4:0] rdest);
        stim[r].enq_en    = 1'b1;
        stim[r].enq.op    = op;
        stim[r].enq.pc    = pc;
        stim[r].enq.rdest = rdest;
    endtask

    task automatic cdb_at(input int r, input int port, input int tag, input logic [31:0] data,
                          input logic [31:0] addr, input logic redirect);
        stim[r].cdb[port].en       = 1'b1;
        stim[r].cdb[port].redirect = redirect;
        stim[r].cdb[port].tag      = ROB_TAG_WIDTH'(tag);
        stim[r].cdb[port].data     = data;
        stim[r].cdb[port].addr     = addr;
    endtask

    task automatic build_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            stim[r] = '0;
        end
        // Fill all 8 entries, then two renames against a full buffer
        for (int r = 0; r < 10; r++) begin
            stim[r].rename = 1'b1;
        end
        enqueue_at(1, OP_ALU, 32'h0000_1000, 5'd1);
        enqueue_at(2, OP_LD,  32'h0000_1004, 5'd2);
        enqueue_at(3, OP_ALU, 32'h0000_1008, 5'd3);
        enqueue_at(4, OP_ST,  32'h0000_100c, 5'd4);
        enqueue_at(5, OP_ALU, 32'h0000_1010, 5'd5);
        enqueue_at(6, OP_ALU, 32'h0000_1014, 5'd6);
        enqueue_at(7, OP_BR,  32'h0000_1018, 5'd7);
        enqueue_at(8, OP_ALU, 32'h0000_101c, 5'd8);
        // Out of order completion, two tags in one cycle, then one tag on both ports
        cdb_at(10, 0, 3, 32'h3333_0003, 32'h0, 1'b0);
        cdb_at(10, 1, 1, 32'h1111_0001, 32'h0, 1'b0);
        cdb_at(11, 0, 2, 32'haaaa_0002, 32'h0, 1'b0);
        cdb_at(11, 1, 2, 32'hbbbb_0002, 32'h0, 1'b0);
        cdb_at(12, 0, 5, 32'h5555_0005, 32'h0, 1'b0);
        cdb_at(13, 1, 0, 32'h0000_0a0a, 32'h0, 1'b0);
        cdb_at(14, 0, 7, 32'h7777_0007, 32'h0, 1'b0);
        cdb_at(15, 0, 4, 32'h4444_0004, 32'h0, 1'b0);
        cdb_at(16, 1, 6, 32'h6666_0006, 32'h0000_2400, 1'b1);
        // After the flush, a non-branch redirect restarts at its own pc
        stim[23].rename = 1'b1;
        stim[24].rename = 1'b1;
        enqueue_at(24, OP_ALU, 32'h0000_3000, 5'd9);
        enqueue_at(25, OP_LD,  32'h0000_3004, 5'd10);
        cdb_at(26, 0, 1, 32'h0b0b_0001, 32'h0, 1'b0);
        cdb_at(27, 1, 0, 32'h0c0c_0000, 32'hdead_0000, 1'b1);
        stim[32].rename = 1'b1;
        for (int r = 0; r < 8; r++) begin
            stim[r].exp_tag = ROB_TAG_WIDTH'(r);
        end
        tag_range(8, 23, 0);
        tag_range(24, 24, 1);
        tag_range(25, 29, 2);
        tag_range(30, 32, 0);
        tag_range(33, NUM_ROWS - 1, 1);
    endtask

    task automatic drive_row(input stim_row_t row);
        i_rename_en <= row.rename;
        i_enq_en    <= row.enq_en;
        i_enq       <= row.enq;
        for (int p = 0; p < CDB_PORTS; p++) begin
            i_cdb[p] <= row.cdb[p];
        end
    endtask

    // Advances the model by one clock edge with the row the DUT just sampled
    task automatic model_step(input stim_row_t row, input int cyc);
        model_entry_t  ent;
        retire_event_t ev;
        logic          full;
        logic          flush;
        full           = (model_q.size() == ROB_DEPTH);
        flush          = model_redirect;
        model_redirect = 1'b0;
        if (!flush && model_q.size() > 0 && model_q[0].rdy) begin
            ent            = model_q.pop_front();
            ev.cycle       = 32'(cyc);
            ev.rec.rdest   = ent.rdest;
            ev.rec.tag     = ent.tag;
            ev.rec.data    = ent.data;
            ev.redirect    = ent.redirect;
            ev.addr        = (ent.op == OP_BR) ? ent.addr : ent.pc;
            expect_q.push_back(ev);
            model_redirect = ent.redirect;
        end
        // The enqueue belongs to the rename of the previous cycle
        if (row.enq_en && !full) begin
            for (int i = 0; i < model_q.size(); i++) begin
                if (model_q[i].tag == last_tag) begin
                    ent       = model_q[i];
                    ent.op    = row.enq.op;
                    ent.pc    = row.enq.pc;
                    ent.rdest = row.enq.rdest;
                    model_q[i] = ent;
                end
            end
        end
        if (row.rename && !full) begin
            ent     = '0;
            ent.tag = model_tail;
            model_q.push_back(ent);
            last_tag   = model_tail;
            model_tail = model_tail + 1'b1;
        end
        for (int p = 0; p < CDB_PORTS; p++) begin
            if (row.cdb[p].en) begin
                for (int i = 0; i < model_q.size(); i++) begin
                    if (model_q[i].tag == row.cdb[p].tag) begin
                        ent          = model_q[i];
                        ent.rdy      = 1'b1;
                        ent.redirect = ent.redirect | row.cdb[p].redirect;
                        ent.data     = row.cdb[p].data;
                        ent.addr     = row.cdb[p].addr;
                        model_q[i]   = ent;
                    end
                end
            end
        end
        if (flush) begin
            model_q.delete();
            model_tail = '0;
        end
    endtask

    task automatic check_cycle(input int cyc);
        retire_event_t ev;
        logic          exp_en;
        logic          exp_stall;
        exp_en = 1'b0;
        if (expect_q.size() > 0) begin
            exp_en = (expect_q[0].cycle == 32'(cyc));
        end
        exp_stall = (model_q.size() == ROB_DEPTH);
        chk_cnt   = chk_cnt + 3;
        assert (o_rename_tag == stim[cyc].exp_tag) else begin
            $display("CHECK FAILED cycle %0d o_rename_tag got %h expected %h",
                     cyc, o_rename_tag, stim[cyc].exp_tag);
            err_cnt++;
        end
        assert (o_rob_stall == exp_stall) else begin
            $display("CHECK FAILED cycle %0d o_rob_stall got %h expected %h",
                     cyc, o_rob_stall, exp_stall);
            err_cnt++;
        end
        assert (o_retire_en == exp_en) else begin
            $display("CHECK FAILED cycle %0d o_retire_en got %h expected %h",
                     cyc, o_retire_en, exp_en);
            err_cnt++;
        end
        if (exp_en) begin
            ev      = expect_q.pop_front();
            chk_cnt = chk_cnt + 2;
            assert (o_retire == ev.rec) else begin
                $display("CHECK FAILED cycle %0d o_retire got %h expected %h",
                         cyc, o_retire, ev.rec);
                err_cnt++;
            end
            assert (o_redirect == ev.redirect) else begin
                $display("CHECK FAILED cycle %0d o_redirect got %h expected %h",
                         cyc, o_redirect, ev.redirect);
                err_cnt++;
            end
            if (ev.redirect) begin
                chk_cnt++;
                assert (o_redirect_addr == ev.addr) else begin
                    $display("CHECK FAILED cycle %0d o_redirect_addr got %h expected %h",
                             cyc, o_redirect_addr, ev.addr);
                    err_cnt++;
                end
            end
        end else begin
            chk_cnt++;
            assert (!o_redirect) else begin
                $display("CHECK FAILED cycle %0d o_redirect got %h expected %h",
                         cyc, o_redirect, 1'b0);
                err_cnt++;
            end
        end
        if (o_retire_en) begin
            retire_seen++;
        end
        if (o_redirect) begin
            redirect_seen++;
        end
    endtask

    initial begin
        n_rst          = 1'b0;
        i_rename_en    = 1'b0;
        i_enq_en       = 1'b0;
        i_enq          = '0;
        for (int p = 0; p < CDB_PORTS; p++) begin
            i_cdb[p] = '0;
        end
        model_redirect = 1'b0;
        model_tail     = '0;
        last_tag       = '0;
        err_cnt        = 0;
        chk_cnt        = 0;
        retire_seen    = 0;
        redirect_seen  = 0;
        build_table();

        repeat (2) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        chk_cnt = chk_cnt + 4;
        assert (!o_retire_en) else begin
            $display("CHECK FAILED after reset o_retire_en got %h expected %h",
                     o_retire_en, 1'b0);
            err_cnt++;
        end
        assert (!o_redirect) else begin
            $display("CHECK FAILED after reset o_redirect got %h expected %h",
                     o_redirect, 1'b0);
            err_cnt++;
        end
        assert (!o_rob_stall) else begin
            $display("CHECK FAILED after reset o_rob_stall got %h expected %h",
                     o_rob_stall, 1'b0);
            err_cnt++;
        end
        assert (o_rename_tag == '0) else begin
            $display("CHECK FAILED after reset o_rename_tag got %h expected %h",
                     o_rename_tag, 3'h0);
            err_cnt++;
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            if (r > 0) begin
                model_step(stim[r-1], r);
            end
            drive_row(stim[r]);
            @(negedge clk);
            check_cycle(r);
        end

        // The scenario retires tags 0 to 6, then tag 0 again, with two redirects
        chk_cnt = chk_cnt + 3;
        assert (expect_q.size() == 0) else begin
            $display("Some expected retires never appeared on the DUT outputs");
            err_cnt++;
        end
        assert (retire_seen == 8) else begin
            $display("CHECK FAILED retire count got %h expected %h", retire_seen, 8);
            err_cnt++;
        end
        assert (redirect_seen == 2) else begin
            $display("CHECK FAILED redirect count got %h expected %h", redirect_seen, 2);
            err_cnt++;
        end

        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verification/reorder_buffer_asserts.sv
// Output protocol checks for the reorder buffer, bound into the top level.
// Covers the redirect pulse and the rename tag of a full buffer.

module reorder_buffer_asserts
    import rob_pkg::*;
(
    input logic                     clk,
    input logic                     n_rst,
    input logic                     i_redirect,
    input logic                     i_retire_en,
    input logic                     i_rob_stall,
    input logic [ROB_TAG_WIDTH-1:0] i_rename_tag
);

    // Redirect is a one-cycle pulse
    redirect_single_pulse: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_redirect |=> !i_redirect
    ) else $error("o_redirect stayed high for two cycles");

    // The flush cycle after a redirect retires nothing
    no_retire_after_redirect: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_redirect |=> !i_retire_en
    ) else $error("o_retire_en high in the cycle after o_redirect");

    // Only a flush may move the tail of a full buffer
    stall_holds_tag: assert property (
        @(posedge clk) disable iff (!n_rst)
        (i_rob_stall && !i_redirect) |=> $stable(i_rename_tag)
    ) else $error("o_rename_tag changed while o_rob_stall was high");

endmodule

bind reorder_buffer reorder_buffer_asserts reorder_buffer_asserts_inst (
    .clk          (clk),
    .n_rst        (n_rst),
    .i_redirect   (o_redirect),
    .i_retire_en  (o_retire_en),
    .i_rob_stall  (o_rob_stall),
    .i_rename_tag (o_rename_tag)
);

// File: hdl/reorder_buffer.sv
// Reorder buffer top level with 8 entries and CDB_PORTS completion ports.
// Rename reserves the tail, enqueue fills it a cycle later, and the head
// retires in program order to the register map.

module reorder_buffer
    import rob_pkg::*;
#(
    parameter int CDB_PORTS = 2
)(
    input  logic                     clk,
    input  logic                     n_rst,

    input  logic                     i_rename_en,
    output logic [ROB_TAG_WIDTH-1:0] o_rename_tag,
    output logic                     o_rob_stall,

    input  logic                     i_enq_en,
    input  rob_enq_t                 i_enq,

    input  cdb_t                     i_cdb [CDB_PORTS],

    output logic                     o_retire_en,
    output rob_retire_t              o_retire,
    output logic                     o_redirect,
    output logic [ADDR_WIDTH-1:0]    o_redirect_addr
);

    logic [ROB_TAG_WIDTH-1:0] head_idx;
    logic [ROB_DEPTH-1:0]     dispatch_sel;
    logic                     enq_strobe;
    logic                     retire_strobe;
    logic                     redirect;
    logic                     head_rdy;
    logic                     head_redirect;
    rob_op_e                  head_op;
    logic [ADDR_WIDTH-1:0]    head_pc;
    logic [ADDR_WIDTH-1:0]    head_addr;
    logic [REG_IDX_WIDTH-1:0] head_rdest;
    logic [DATA_WIDTH-1:0]    head_data;

    assign o_redirect = redirect;

    rob_ptr_ctrl rob_ptr_ctrl_inst (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_rename_en     (i_rename_en),
        .i_enq_en        (i_enq_en),
        .i_head_rdy      (head_rdy),
        .i_head_redirect (head_redirect),
        .o_head_idx      (head_idx),
        .o_tail_idx      (o_rename_tag),
        .o_full          (o_rob_stall),
        .o_dispatch_sel  (dispatch_sel),
        .o_enq_strobe    (enq_strobe),
        .o_retire_strobe (retire_strobe),
        .o_redirect      (redirect)
    );

    rob_entry_store #(
        .CDB_PORTS (CDB_PORTS)
    ) rob_entry_store_inst (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_dispatch_sel  (dispatch_sel),
        .i_enq_strobe    (enq_strobe),
        .i_enq           (i_enq),
        .i_cdb           (i_cdb),
        .i_flush         (redirect),
        .i_head_idx      (head_idx),
        .o_head_rdy      (head_rdy),
        .o_head_redirect (head_redirect),
        .o_head_op       (head_op),
        .o_head_pc       (head_pc),
        .o_head_addr     (head_addr),
        .o_head_rdest    (head_rdest),
        .o_head_data     (head_data)
    );

    rob_retire_stage rob_retire_stage_inst (
        .clk             (clk),
        .n_rst           (n_rst),
        .i_retire_strobe (retire_strobe),
        .i_redirect      (redirect),
        .i_head_idx      (head_idx),
        .i_head_op       (head_op),
        .i_head_pc       (head_pc),
        .i_head_addr     (head_addr),
        .i_head_rdest    (head_rdest),
        .i_head_data     (head_data),
        .o_retire_en     (o_retire_en),
        .o_retire        (o_retire),
        .o_redirect_addr (o_redirect_addr)
    );

endmodule

// File: hdl/rob_retire_stage.sv
// Registered retire port toward the register map.
// Also latches the restart address that goes out with a redirect.

module rob_retire_stage
    import rob_pkg::*;
(
    input  logic                     clk,
    input  logic                     n_rst,

    input  logic                     i_retire_strobe,
    input  logic                     i_redirect,
    input  logic [ROB_TAG_WIDTH-1:0] i_head_idx,
    input  rob_op_e                  i_head_op,
    input  logic [ADDR_WIDTH-1:0]    i_head_pc,
    input  logic [ADDR_WIDTH-1:0]    i_head_addr,
    input  logic [REG_IDX_WIDTH-1:0] i_head_rdest,
    input  logic [DATA_WIDTH-1:0]    i_head_data,

    output logic                     o_retire_en,
    output rob_retire_t              o_retire,
    output logic [ADDR_WIDTH-1:0]    o_redirect_addr
);

    // Nothing retires while the flush is in progress
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_retire_en <= 1'b0;
        end else begin
            o_retire_en <= i_retire_strobe & ~i_redirect;
        end
    end

    // Branches restart at their target, anything else replays from its own pc
    always_ff @(posedge clk) begin
        if (i_retire_strobe) begin
            o_retire.rdest  <= i_head_rdest;
            o_retire.tag    <= i_head_idx;
            o_retire.data   <= i_head_data;
            o_redirect_addr <= (i_head_op == OP_BR) ? i_head_addr : i_head_pc;
        end
    end

endmodule

// File: hdl/rob_entry_store.sv
// Entry array of the reorder buffer.
// Loaded by the dispatcher, completed by the CDB ports and read at the head
// for the retire decision and the retire record.

module rob_entry_store
    import rob_pkg::*;
#(
    parameter int CDB_PORTS = 2
)(
    input  logic                     clk,
    input  logic                     n_rst,

    input  logic [ROB_DEPTH-1:0]     i_dispatch_sel,
    input  logic                     i_enq_strobe,
    input  rob_enq_t                 i_enq,
    input  cdb_t                     i_cdb [CDB_PORTS],
    input  logic                     i_flush,
    input  logic [ROB_TAG_WIDTH-1:0] i_head_idx,

    output logic                     o_head_rdy,
    output logic                     o_head_redirect,
    output rob_op_e                  o_head_op,
    output logic [ADDR_WIDTH-1:0]    o_head_pc,
    output logic [ADDR_WIDTH-1:0]    o_head_addr,
    output logic [REG_IDX_WIDTH-1:0] o_head_rdest,
    output logic [DATA_WIDTH-1:0]    o_head_data
);

    logic [ROB_DEPTH-1:0]     rdy_q;
    logic [ROB_DEPTH-1:0]     redirect_q;
    logic [ROB_DEPTH-1:0]     rdy_d;
    logic [ROB_DEPTH-1:0]     redirect_d;
    logic [ROB_DEPTH-1:0]     dispatch_en;
    rob_op_e                  op_q    [ROB_DEPTH];
    logic [ADDR_WIDTH-1:0]    pc_q    [ROB_DEPTH];
    logic [REG_IDX_WIDTH-1:0] rdest_q [ROB_DEPTH];
    logic [ADDR_WIDTH-1:0]    addr_q  [ROB_DEPTH];
    logic [DATA_WIDTH-1:0]    data_q  [ROB_DEPTH];
    logic [ADDR_WIDTH-1:0]    addr_d  [ROB_DEPTH];
    logic [DATA_WIDTH-1:0]    data_d  [ROB_DEPTH];

    assign dispatch_en = i_dispatch_sel & {ROB_DEPTH{i_enq_strobe}};

    // Ports are scanned from low to high, so the last matching port wins
    always_comb begin
        for (int e = 0; e < ROB_DEPTH; e++) begin
            rdy_d[e]      = rdy_q[e];
            redirect_d[e] = redirect_q[e];
            addr_d[e]     = addr_q[e];
            data_d[e]     = data_q[e];
            for (int p = 0; p < CDB_PORTS; p++) begin
                if (i_cdb[p].en && (i_cdb[p].tag == ROB_TAG_WIDTH'(e))) begin
                    rdy_d[e]      = 1'b1;
                    redirect_d[e] = redirect_d[e] | i_cdb[p].redirect;
                    addr_d[e]     = i_cdb[p].addr;
                    data_d[e]     = i_cdb[p].data;
                end
            end
        end
    end

    // A fresh dispatch starts its entry as not ready
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            rdy_q      <= '0;
            redirect_q <= '0;
        end else if (i_flush) begin
            rdy_q      <= '0;
            redirect_q <= '0;
        end else begin
            rdy_q      <= rdy_d & ~dispatch_en;
            redirect_q <= redirect_d & ~dispatch_en;
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < ROB_DEPTH; e++) begin
            addr_q[e] <= addr_d[e];
            data_q[e] <= data_d[e];
            if (dispatch_en[e]) begin
                op_q[e]    <= i_enq.op;
                pc_q[e]    <= i_enq.pc;
                rdest_q[e] <= i_enq.rdest;
            end
        end
    end

    assign o_head_rdy      = rdy_q[i_head_idx];
    assign o_head_redirect = redirect_q[i_head_idx];
    assign o_head_op       = op_q[i_head_idx];
    assign o_head_pc       = pc_q[i_head_idx];
    assign o_head_addr     = addr_q[i_head_idx];
    assign o_head_rdest    = rdest_q[i_head_idx];
    assign o_head_data     = data_q[i_head_idx];

endmodule

// File: hdl/rob_ptr_ctrl.sv
// Head and tail pointer control for the reorder buffer.
// Gates rename and enqueue against the full flag, decides retire and
// raises the one-cycle redirect that flushes the buffer.

module rob_ptr_ctrl
    import rob_pkg::*;
(
    input  logic                     clk,
    input  logic                     n_rst,

    input  logic                     i_rename_en,
    input  logic                     i_enq_en,
    input  logic                     i_head_rdy,
    input  logic                     i_head_redirect,

    output logic [ROB_TAG_WIDTH-1:0] o_head_idx,
    output logic [ROB_TAG_WIDTH-1:0] o_tail_idx,
    output logic                     o_full,
    output logic [ROB_DEPTH-1:0]     o_dispatch_sel,
    output logic                     o_enq_strobe,
    output logic                     o_retire_strobe,
    output logic                     o_redirect
);

    // The extra top bit tells a full buffer apart from an empty one
    logic [ROB_TAG_WIDTH:0] head_q;
    logic [ROB_TAG_WIDTH:0] tail_q;
    logic [ROB_TAG_WIDTH:0] head_next;
    logic [ROB_TAG_WIDTH:0] tail_next;
    logic                   full_q;
    logic                   empty_q;
    logic                   redirect_q;
    logic                   rename_ok;
    logic                   retire_ok;
    logic [ROB_DEPTH-1:0]   dispatch_sel_q;

    assign rename_ok = i_rename_en & ~full_q;
    assign retire_ok = i_head_rdy & ~empty_q & ~redirect_q;

    always_comb begin
        if (redirect_q) begin
            head_next = '0;
            tail_next = '0;
        end else begin
            head_next = retire_ok ? head_q + 1'b1 : head_q;
            tail_next = rename_ok ? tail_q + 1'b1 : tail_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_next;
            tail_q <= tail_next;
        end
    end

    // Flags are computed from the next pointers so they line up with them
    always_ff @(posedge clk) begin
        if (!n_rst || redirect_q) begin
            full_q  <= 1'b0;
            empty_q <= 1'b1;
        end else begin
            full_q  <= ({~tail_next[ROB_TAG_WIDTH], tail_next[ROB_TAG_WIDTH-1:0]} == head_next);
            empty_q <= (tail_next == head_next);
        end
    end

    // The entry reserved now is filled by the enqueue of the next cycle
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            dispatch_sel_q <= '0;
        end else if (rename_ok) begin
            dispatch_sel_q <= ROB_DEPTH'(1) << tail_q[ROB_TAG_WIDTH-1:0];
        end
    end

    // A retiring entry marked redirect gives a single-cycle pulse
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= retire_ok & i_head_redirect;
        end
    end

    assign o_head_idx      = head_q[ROB_TAG_WIDTH-1:0];
    assign o_tail_idx      = tail_q[ROB_TAG_WIDTH-1:0];
    assign o_full          = full_q;
    assign o_dispatch_sel  = dispatch_sel_q;
    assign o_enq_strobe    = i_enq_en & ~full_q;
    assign o_retire_strobe = retire_ok;
    assign o_redirect      = redirect_q;

endmodule

// File: hdl/rob_pkg.sv
// Shared widths, op encoding and bus records for the reorder buffer.
// Imported by every RTL module and by the testbench.

package rob_pkg;

    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 32;
    localparam int REG_IDX_WIDTH = 5;
    localparam int ROB_TAG_WIDTH = 3;
    localparam int ROB_DEPTH     = 1 << ROB_TAG_WIDTH;

    // Op class of an entry
    // Only OP_BR changes how the restart address is chosen
    typedef enum logic [1:0] {
        OP_ALU = 2'b00,
        OP_BR  = 2'b01,
        OP_LD  = 2'b10,
        OP_ST  = 2'b11
    } rob_op_e;

    // Dispatch payload written into the entry reserved by the previous rename
    typedef struct packed {
        rob_op_e                  op;
        logic [ADDR_WIDTH-1:0]    pc;
        logic [REG_IDX_WIDTH-1:0] rdest;
    } rob_enq_t;

    // One common data bus port
    // addr carries the branch target and is ignored for non-branch ops
    typedef struct packed {
        logic                     en;
        logic                     redirect;
        logic [ROB_TAG_WIDTH-1:0] tag;
        logic [DATA_WIDTH-1:0]    data;
        logic [ADDR_WIDTH-1:0]    addr;
    } cdb_t;

    // Record handed to the register map when an entry retires
    typedef struct packed {
        logic [REG_IDX_WIDTH-1:0] rdest;
        logic [ROB_TAG_WIDTH-1:0] tag;
        logic [DATA_WIDTH-1:0]    data;
    } rob_retire_t;

endpackage
